// File: spec_cfg_pkg.sv
package spec_cfg_pkg;

  // set addressing.
  localparam int set_bits = 4;
  localparam int set_count = 16;

  // one bit per line slot in a set.
  localparam int slot_count = 32;
  localparam int slot_bits = 5;

  // port counts of the table.
  localparam int read_ports = 2;
  localparam int commit_ports = 2;

endpackage

// File: spec_req_pkg.sv
package spec_req_pkg;

  // alloc replaces the row, merge adds one bit to it.
  typedef enum logic {
    fill_merge = 1'b0,
    fill_alloc = 1'b1
  } fill_op_e;

  typedef struct packed {
    logic                               valid;
    fill_op_e                           op;
    logic [spec_cfg_pkg::set_bits-1:0]  set_addr;
    logic [spec_cfg_pkg::slot_bits-1:0] slot;
    logic                               thread;
  } fill_req_t;

  typedef struct packed {
    logic                               valid;
    logic [spec_cfg_pkg::set_bits-1:0]  set_addr;
    logic [spec_cfg_pkg::slot_bits-1:0] slot;
  } commit_req_t;

  typedef struct packed {
    logic                              clk_en;
    logic [spec_cfg_pkg::set_bits-1:0] set_addr;
    logic                              thread;
  } read_req_t;

  // decoded writes as seen by the table.
  typedef struct packed {
    logic                                wen;
    fill_op_e                            op;
    logic [spec_cfg_pkg::set_bits-1:0]   set_addr;
    logic [spec_cfg_pkg::slot_count-1:0] mask;
    logic                                thread;
  } fill_wr_t;

  typedef struct packed {
    logic                                wen;
    logic [spec_cfg_pkg::set_bits-1:0]   set_addr;
    logic [spec_cfg_pkg::slot_count-1:0] mask;
  } commit_wr_t;

  // exception on one thread.
  typedef struct packed {
    logic valid;
    logic thread;
  } flush_t;

endpackage

// File: spec_req_decode.sv
`timescale 1ns/1ns

module spec_req_decode (
  input  logic                     clk,
  input  logic                     rst,
  input  spec_req_pkg::fill_req_t  fill_req,
  input  spec_req_pkg::commit_req_t commit_req [spec_cfg_pkg::commit_ports],
  output spec_req_pkg::fill_wr_t   fill_wr,
  output spec_req_pkg::commit_wr_t commit_wr [spec_cfg_pkg::commit_ports]
);

  spec_req_pkg::fill_wr_t   fill_next;
  spec_req_pkg::commit_wr_t commit_next [spec_cfg_pkg::commit_ports];

  // expand a slot index into a single mask bit.
  function automatic logic [spec_cfg_pkg::slot_count-1:0] slot_onehot(
    input logic [spec_cfg_pkg::slot_bits-1:0] slot
  );
    logic [spec_cfg_pkg::slot_count-1:0] mask;
    mask = '0;
    mask[slot] = 1'b1;
    return mask;
  endfunction

  always_comb begin
    fill_next.wen = fill_req.valid;
    fill_next.op = fill_req.op;
    fill_next.set_addr = fill_req.set_addr;
    fill_next.mask = slot_onehot(fill_req.slot);
    fill_next.thread = fill_req.thread;
  end

  always_comb begin
    for (int i = 0; i < spec_cfg_pkg::commit_ports; i++) begin
      commit_next[i].wen = commit_req[i].valid;
      commit_next[i].set_addr = commit_req[i].set_addr;
      commit_next[i].mask = slot_onehot(commit_req[i].slot);
    end

    // fold a later commit into an earlier one to the same set.
    // the table then never sees two commit writes to one row.
    for (int i = 1; i < spec_cfg_pkg::commit_ports; i++) begin
      for (int j = 0; j < i; j++) begin
        if (commit_next[i].wen && commit_next[j].wen &&
            commit_next[i].set_addr == commit_next[j].set_addr) begin
          commit_next[j].mask = commit_next[j].mask | commit_next[i].mask;
          commit_next[i].wen = 1'b0;
        end
      end
    end
  end

  // payload loads every cycle, only the write enables see reset.
  always_ff @(posedge clk) begin
    fill_wr <= fill_next;
    commit_wr <= commit_next;
    if (rst) begin
      fill_wr.wen <= 1'b0;
      for (int i = 0; i < spec_cfg_pkg::commit_ports; i++) begin
        commit_wr[i].wen <= 1'b0;
      end
    end
  end

endmodule

// File: spec_vis_table.sv
`timescale 1ns/1ns

module spec_vis_table (
  input  logic                                clk,
  input  logic                                rst,
  input  spec_req_pkg::read_req_t             read_req [spec_cfg_pkg::read_ports],
  output logic [spec_cfg_pkg::slot_count-1:0] read_mask [spec_cfg_pkg::read_ports],
  input  spec_req_pkg::fill_wr_t              fill_wr,
  input  spec_req_pkg::commit_wr_t            commit_wr [spec_cfg_pkg::commit_ports],
  input  spec_req_pkg::flush_t                flush
);

  // one bit per slot in each set.
  logic [spec_cfg_pkg::slot_count-1:0] enable_q [spec_cfg_pkg::set_count];
  logic [spec_cfg_pkg::slot_count-1:0] confirm_q [spec_cfg_pkg::set_count];
  logic [spec_cfg_pkg::slot_count-1:0] thread_q [spec_cfg_pkg::set_count];

  // enable rows after the flush of this edge.
  logic [spec_cfg_pkg::slot_count-1:0] enable_kept [spec_cfg_pkg::set_count];

  // captured read address and thread per port.
  logic [spec_cfg_pkg::set_bits-1:0] rd_set_q [spec_cfg_pkg::read_ports];
  logic                              rd_thread_q [spec_cfg_pkg::read_ports];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < spec_cfg_pkg::read_ports; p++) begin
        rd_set_q[p] <= '0;
        rd_thread_q[p] <= 1'b0;
      end
    end else begin
      for (int p = 0; p < spec_cfg_pkg::read_ports; p++) begin
        if (read_req[p].clk_en) begin
          rd_set_q[p] <= read_req[p].set_addr;
          rd_thread_q[p] <= read_req[p].thread;
        end
      end
    end
  end

  // visible when confirmed, or filled by the reading thread.
  always_comb begin
    for (int p = 0; p < spec_cfg_pkg::read_ports; p++) begin
      read_mask[p] = confirm_q[rd_set_q[p]] |
                     (enable_q[rd_set_q[p]] &
                      ~(thread_q[rd_set_q[p]] ^ {spec_cfg_pkg::slot_count{rd_thread_q[p]}}));
    end
  end

  // a flush keeps confirmed bits and bits owned by the other thread.
  always_comb begin
    for (int s = 0; s < spec_cfg_pkg::set_count; s++) begin
      if (flush.valid) begin
        enable_kept[s] = enable_q[s] &
                         (confirm_q[s] |
                          (thread_q[s] ^ {spec_cfg_pkg::slot_count{flush.thread}}));
      end else begin
        enable_kept[s] = enable_q[s];
      end
    end
  end

  // flush, then commits, then the fill. later writes win.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < spec_cfg_pkg::set_count; s++) begin
        enable_q[s] <= '0;
        confirm_q[s] <= '0;
      end
    end else begin
      for (int s = 0; s < spec_cfg_pkg::set_count; s++) begin
        enable_q[s] <= enable_kept[s];
      end

      for (int c = 0; c < spec_cfg_pkg::commit_ports; c++) begin
        if (commit_wr[c].wen) begin
          confirm_q[commit_wr[c].set_addr] <= confirm_q[commit_wr[c].set_addr] |
                                              commit_wr[c].mask;
        end
      end

      if (fill_wr.wen) begin
        case (fill_wr.op)
          spec_req_pkg::fill_alloc: begin
            enable_q[fill_wr.set_addr] <= fill_wr.mask;
            confirm_q[fill_wr.set_addr] <= '0;
          end
          spec_req_pkg::fill_merge: begin
            enable_q[fill_wr.set_addr] <= enable_kept[fill_wr.set_addr] | fill_wr.mask;
          end
        endcase
      end
    end
  end

  // thread that filled each slot.
  always_ff @(posedge clk) begin
    if (fill_wr.wen) begin
      thread_q[fill_wr.set_addr] <=
        (thread_q[fill_wr.set_addr] & ~fill_wr.mask) |
        ({spec_cfg_pkg::slot_count{fill_wr.thread}} & fill_wr.mask);
    end
  end

endmodule

// File: spec_track_top.sv
`timescale 1ns/1ns

module spec_track_top (
  input  logic                                clk,
  input  logic                                rst,
  input  spec_req_pkg::fill_req_t             fill_req,
  input  spec_req_pkg::commit_req_t           commit_req [spec_cfg_pkg::commit_ports],
  input  spec_req_pkg::read_req_t             read_req [spec_cfg_pkg::read_ports],
  input  spec_req_pkg::flush_t                flush,
  output logic [spec_cfg_pkg::slot_count-1:0] read_mask [spec_cfg_pkg::read_ports]
);

  // decoded writes, one cycle behind the requests.
  spec_req_pkg::fill_wr_t   fill_wr;
  spec_req_pkg::commit_wr_t commit_wr [spec_cfg_pkg::commit_ports];

  spec_req_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .fill_req   (fill_req),
    .commit_req (commit_req),
    .fill_wr    (fill_wr),
    .commit_wr  (commit_wr)
  );

  // reads and the flush bypass the decoder.
  spec_vis_table u_table (
    .clk       (clk),
    .rst       (rst),
    .read_req  (read_req),
    .read_mask (read_mask),
    .fill_wr   (fill_wr),
    .commit_wr (commit_wr),
    .flush     (flush)
  );

endmodule

// File: tb_spec_model.svh
  // reference model of the visibility table, kept at request level.
  logic [spec_cfg_pkg::slot_count-1:0] model_enable [spec_cfg_pkg::set_count];
  logic [spec_cfg_pkg::slot_count-1:0] model_confirm [spec_cfg_pkg::set_count];
  logic [spec_cfg_pkg::slot_count-1:0] model_thread [spec_cfg_pkg::set_count];

  // requests seen at the last edge, applied at the next one.
  spec_req_pkg::fill_req_t   pend_fill;
  spec_req_pkg::commit_req_t pend_commit [spec_cfg_pkg::commit_ports];

  // set and thread each read port last captured.
  logic [spec_cfg_pkg::set_bits-1:0] cap_set [spec_cfg_pkg::read_ports];
  logic                              cap_thread [spec_cfg_pkg::read_ports];

  // a slot is visible when confirmed, or filled by the reading thread.
  function automatic logic [spec_cfg_pkg::slot_count-1:0] ref_mask(
    input logic [spec_cfg_pkg::set_bits-1:0] set_addr,
    input logic                              thread
  );
    logic [spec_cfg_pkg::slot_count-1:0] mask;
    for (int i = 0; i < spec_cfg_pkg::slot_count; i++) begin
      mask[i] = model_confirm[set_addr][i] ||
                (model_enable[set_addr][i] && model_thread[set_addr][i] == thread);
    end
    return mask;
  endfunction

  task automatic clear_model();
    for (int s = 0; s < spec_cfg_pkg::set_count; s++) begin
      model_enable[s] = '0;
      model_confirm[s] = '0;
      model_thread[s] = '0;
    end
    pend_fill = '0;
    for (int c = 0; c < spec_cfg_pkg::commit_ports; c++) begin
      pend_commit[c] = '0;
    end
    for (int p = 0; p < spec_cfg_pkg::read_ports; p++) begin
      cap_set[p] = '0;
      cap_thread[p] = 1'b0;
    end
  endtask

  task automatic advance_model();
    // the flush is judged on the rows as they stood before this edge.
    if (flush.valid) begin
      for (int s = 0; s < spec_cfg_pkg::set_count; s++) begin
        for (int i = 0; i < spec_cfg_pkg::slot_count; i++) begin
          if (model_enable[s][i] && !model_confirm[s][i] &&
              model_thread[s][i] == flush.thread) begin
            model_enable[s][i] = 1'b0;
          end
        end
      end
    end
    for (int c = 0; c < spec_cfg_pkg::commit_ports; c++) begin
      if (pend_commit[c].valid) begin
        model_confirm[pend_commit[c].set_addr][pend_commit[c].slot] = 1'b1;
      end
    end
    if (pend_fill.valid) begin
      if (pend_fill.op == spec_req_pkg::fill_alloc) begin
        model_enable[pend_fill.set_addr] = '0;
        model_confirm[pend_fill.set_addr] = '0;
      end
      model_enable[pend_fill.set_addr][pend_fill.slot] = 1'b1;
      model_thread[pend_fill.set_addr][pend_fill.slot] = pend_fill.thread;
    end
    pend_fill = fill_req;
    for (int c = 0; c < spec_cfg_pkg::commit_ports; c++) begin
      pend_commit[c] = commit_req[c];
    end
    for (int p = 0; p < spec_cfg_pkg::read_ports; p++) begin
      if (read_req[p].clk_en) begin
        cap_set[p] = read_req[p].set_addr;
        cap_thread[p] = read_req[p].thread;
      end
    end
  endtask

// File: tb_spec_track.sv
`timescale 1ns/1ns

module tb_spec_track;

  localparam int random_cycles = 1500;
  // about twice the length of all stimulus.
  localparam int cycle_limit = 4000;

  logic                                clk;
  logic                                rst;
  spec_req_pkg::fill_req_t             fill_req;
  spec_req_pkg::commit_req_t           commit_req [spec_cfg_pkg::commit_ports];
  spec_req_pkg::read_req_t             read_req [spec_cfg_pkg::read_ports];
  spec_req_pkg::flush_t                flush;
  logic [spec_cfg_pkg::slot_count-1:0] read_mask [spec_cfg_pkg::read_ports];

  int seed;
  int cycle_count;
  int check_count;
  int err_count;
  int test_count;
  int test_errs;

  `include "tb_spec_model.svh"

  spec_track_top uut (
    .clk        (clk),
    .rst        (rst),
    .fill_req   (fill_req),
    .commit_req (commit_req),
    .read_req   (read_req),
    .flush      (flush),
    .read_mask  (read_mask)
  );

  always #2 clk = ~clk;

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic clear_reqs();
    fill_req.valid = 1'b0;
    for (int c = 0; c < spec_cfg_pkg::commit_ports; c++) begin
      commit_req[c].valid = 1'b0;
    end
    for (int p = 0; p < spec_cfg_pkg::read_ports; p++) begin
      read_req[p].clk_en = 1'b0;
    end
    flush.valid = 1'b0;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    clear_reqs();
  endtask

  // one edge registers a request, the next applies it.
  task automatic wait_applied();
    repeat (2) next_cycle();
  endtask

  task automatic drive_fill(input spec_req_pkg::fill_op_e op, input int set_addr,
                            input int slot, input int thread);
    fill_req.valid = 1'b1;
    fill_req.op = op;
    fill_req.set_addr = set_addr[spec_cfg_pkg::set_bits-1:0];
    fill_req.slot = slot[spec_cfg_pkg::slot_bits-1:0];
    fill_req.thread = thread[0];
  endtask

  task automatic drive_commit(input int port, input int set_addr, input int slot);
    commit_req[port].valid = 1'b1;
    commit_req[port].set_addr = set_addr[spec_cfg_pkg::set_bits-1:0];
    commit_req[port].slot = slot[spec_cfg_pkg::slot_bits-1:0];
  endtask

  task automatic drive_flush(input int thread);
    flush.valid = 1'b1;
    flush.thread = thread[0];
  endtask

  task automatic capture_reads(input int set0, input int thr0, input int set1, input int thr1);
    read_req[0].clk_en = 1'b1;
    read_req[0].set_addr = set0[spec_cfg_pkg::set_bits-1:0];
    read_req[0].thread = thr0[0];
    read_req[1].clk_en = 1'b1;
    read_req[1].set_addr = set1[spec_cfg_pkg::set_bits-1:0];
    read_req[1].thread = thr1[0];
    next_cycle();
  endtask

  task automatic random_cycle();
    int r;
    r = $random(seed);
    fill_req.valid = r[0];
    fill_req.op = (r[1] & r[30]) ? spec_req_pkg::fill_alloc : spec_req_pkg::fill_merge;
    fill_req.set_addr = r[5:2];
    fill_req.slot = r[10:6];
    fill_req.thread = r[11];
    commit_req[0].valid = r[12] & r[13];
    commit_req[0].set_addr = r[17:14];
    commit_req[0].slot = r[22:18];
    commit_req[1].valid = r[23] & r[24];
    // share the set of port 0 half the time so that commits merge.
    commit_req[1].set_addr = r[25] ? r[17:14] : r[29:26];
    r = $random(seed);
    commit_req[1].slot = r[4:0];
    flush.valid = (r[8:5] == 4'h0);
    flush.thread = r[9];
    read_req[0].clk_en = r[10];
    read_req[0].set_addr = r[14:11];
    read_req[0].thread = r[15];
    read_req[1].clk_en = r[16];
    read_req[1].set_addr = r[20:17];
    read_req[1].thread = r[21];
  endtask

  task automatic end_test(input string name);
    next_cycle();
    test_count++;
    $display("test %0d %s done with %0d errors", test_count, name, err_count - test_errs);
    test_errs = err_count;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      clear_model();
    end else begin
      advance_model();
    end
  end

  // held ports are compared as well because their masks follow later writes.
  always @(negedge clk) begin
    if (!rst) begin
      for (int p = 0; p < spec_cfg_pkg::read_ports; p++) begin
        check_val($sformatf("read_mask[%0d]", p), read_mask[p],
                  ref_mask(cap_set[p], cap_thread[p]));
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    seed = 32'he9e1ccd1;
    cycle_count = 0;
    check_count = 0;
    err_count = 0;
    test_count = 0;
    test_errs = 0;
    fill_req = '0;
    for (int c = 0; c < spec_cfg_pkg::commit_ports; c++) begin
      commit_req[c] = '0;
    end
    for (int p = 0; p < spec_cfg_pkg::read_ports; p++) begin
      read_req[p] = '0;
    end
    flush = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int s = 0; s < spec_cfg_pkg::set_count; s++) begin
      for (int t = 0; t < 2; t++) begin
        capture_reads(s, t, s, 1 - t);
        check_val("read_mask[0]", read_mask[0], 32'h0);
        check_val("read_mask[1]", read_mask[1], 32'h0);
      end
    end
    end_test("reset_clear");

    drive_fill(spec_req_pkg::fill_merge, 3, 5, 0);
    wait_applied();
    capture_reads(3, 0, 3, 1);
    check_val("read_mask[0]", read_mask[0], 32'h0000_0020);
    check_val("read_mask[1]", read_mask[1], 32'h0);
    drive_commit(0, 3, 5);
    wait_applied();
    capture_reads(3, 0, 3, 1);
    check_val("read_mask[0]", read_mask[0], 32'h0000_0020);
    check_val("read_mask[1]", read_mask[1], 32'h0000_0020);
    drive_fill(spec_req_pkg::fill_alloc, 3, 12, 1);
    wait_applied();
    capture_reads(3, 0, 3, 1);
    check_val("read_mask[0]", read_mask[0], 32'h0);
    check_val("read_mask[1]", read_mask[1], 32'h0000_1000);
    end_test("fill_merge_alloc");

    drive_fill(spec_req_pkg::fill_merge, 7, 2, 0);
    wait_applied();
    drive_commit(0, 7, 2);
    wait_applied();
    capture_reads(7, 0, 7, 1);
    check_val("read_mask[0]", read_mask[0], 32'h0000_0004);
    check_val("read_mask[1]", read_mask[1], 32'h0000_0004);
    drive_commit(0, 7, 10);
    drive_commit(1, 7, 20);
    wait_applied();
    capture_reads(7, 0, 7, 1);
    check_val("read_mask[0]", read_mask[0], 32'h0010_0404);
    check_val("read_mask[1]", read_mask[1], 32'h0010_0404);
    end_test("commit");

    drive_fill(spec_req_pkg::fill_merge, 1, 0, 0);
    next_cycle();
    drive_fill(spec_req_pkg::fill_merge, 1, 1, 1);
    next_cycle();
    drive_fill(spec_req_pkg::fill_merge, 2, 3, 0);
    next_cycle();
    drive_fill(spec_req_pkg::fill_merge, 2, 4, 0);
    drive_commit(0, 2, 3);
    next_cycle();
    // this fill lands at the flush edge.
    drive_fill(spec_req_pkg::fill_merge, 2, 6, 0);
    next_cycle();
    drive_flush(0);
    next_cycle();
    capture_reads(1, 0, 1, 1);
    check_val("read_mask[0]", read_mask[0], 32'h0);
    check_val("read_mask[1]", read_mask[1], 32'h0000_0002);
    capture_reads(2, 0, 2, 1);
    check_val("read_mask[0]", read_mask[0], 32'h0000_0048);
    check_val("read_mask[1]", read_mask[1], 32'h0000_0008);
    capture_reads(3, 1, 7, 1);
    check_val("read_mask[0]", read_mask[0], 32'h0000_1000);
    check_val("read_mask[1]", read_mask[1], 32'h0010_0404);
    end_test("flush");

    capture_reads(9, 1, 9, 0);
    check_val("read_mask[0]", read_mask[0], 32'h0);
    check_val("read_mask[1]", read_mask[1], 32'h0);
    read_req[0].set_addr = 4'd4;
    read_req[0].thread = 1'b0;
    read_req[1].set_addr = 4'd5;
    read_req[1].thread = 1'b1;
    drive_fill(spec_req_pkg::fill_merge, 9, 30, 1);
    next_cycle();
    drive_commit(1, 9, 1);
    wait_applied();
    check_val("read_mask[0]", read_mask[0], 32'h4000_0002);
    check_val("read_mask[1]", read_mask[1], 32'h0000_0002);
    end_test("read_hold");

    for (int i = 0; i < random_cycles; i++) begin
      random_cycle();
      next_cycle();
    end
    wait_applied();
    end_test("random_mix");

    @(negedge clk);
    #1;
    $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: spec_track_top.f
+incdir+.
spec_cfg_pkg.sv
spec_req_pkg.sv
spec_req_decode.sv
spec_vis_table.sv
spec_track_top.sv
tb_spec_track.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_spec_track
FILELIST = spec_track_top.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

# the run passes only when the log holds the pass message.
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
